// File: design/periph_pkg.sv
package periph_pkg;

    // Bus widths
    parameter int XLEN  = 32;
    parameter int SEL_W = XLEN / 8;    // One select bit per byte lane

    // Address windows, a target hits when (addr & MASK) == BASE
    parameter logic [XLEN-1:0] DMEM_BASE  = 32'h8000_0000;
    parameter logic [XLEN-1:0] DMEM_MASK  = 32'hFFFF_F000;    // 4 KB
    parameter logic [XLEN-1:0] CLINT_BASE = 32'h0200_0000;
    parameter logic [XLEN-1:0] CLINT_MASK = 32'hFFFF_0000;    // 64 KB
    parameter logic [XLEN-1:0] PLIC_BASE  = 32'h0C00_0000;
    parameter logic [XLEN-1:0] PLIC_MASK  = 32'hFFC0_0000;    // 4 MB

    // CLINT register offsets
    parameter logic [XLEN-1:0] CLINT_MSIP_OFF        = 32'h0000_0000;
    parameter logic [XLEN-1:0] CLINT_MTIMECMP_LO_OFF = 32'h0000_4000;
    parameter logic [XLEN-1:0] CLINT_MTIMECMP_HI_OFF = 32'h0000_4004;
    parameter logic [XLEN-1:0] CLINT_MTIME_LO_OFF    = 32'h0000_BFF8;
    parameter logic [XLEN-1:0] CLINT_MTIME_HI_OFF    = 32'h0000_BFFC;

    // PLIC register offsets
    // Priority of source n sits at PLIC_PRIO_OFF + 4*n, source 0 reserved
    parameter logic [XLEN-1:0] PLIC_PRIO_OFF      = 32'h0000_0000;
    parameter logic [XLEN-1:0] PLIC_PENDING_OFF   = 32'h0000_1000;
    parameter logic [XLEN-1:0] PLIC_ENABLE_OFF    = 32'h0000_2000;
    parameter logic [XLEN-1:0] PLIC_THRESHOLD_OFF = 32'h0020_0000;
    parameter logic [XLEN-1:0] PLIC_CLAIM_OFF     = 32'h0020_0004;

    parameter int PLIC_PRIO_W = 3;

endpackage : periph_pkg

// File: design/dmem.sv
`timescale 1ns/10ps

module dmem #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic                            clk,
    input  logic                            rst_i,

    input  logic                            sel_i,
    input  logic                            we_i,
    input  logic [periph_pkg::SEL_W-1:0]    be_i,
    input  logic [periph_pkg::XLEN-1:0]     addr_i,
    input  logic [periph_pkg::XLEN-1:0]     wdata_i,
    output logic [periph_pkg::XLEN-1:0]     rdata_o
);

localparam int IDX_W = $clog2(DMEM_WORDS);

logic [periph_pkg::XLEN-1:0]    mem [DMEM_WORDS];
logic [IDX_W-1:0]               idx;

// Word index, upper address bits ignored so the window wraps
assign idx = addr_i[IDX_W+1:2];

always_ff @(posedge clk) begin
    if (sel_i && we_i) begin
        for (int b = 0; b < periph_pkg::SEL_W; b++) begin
            if (be_i[b]) begin
                mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];    // Enabled lanes only
            end
        end
    end
end

// Old word on a write strobe
always_ff @(posedge clk) begin
    if (rst_i) begin
        rdata_o <= '0;
    end else if (sel_i) begin
        rdata_o <= mem[idx];
    end
end

endmodule : dmem

// File: design/clint.sv
`timescale 1ns/10ps

module clint #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                            clk,
    input  logic                            rst_i,

    input  logic                            sel_i,
    input  logic                            we_i,
    input  logic [periph_pkg::XLEN-1:0]     addr_i,
    input  logic [periph_pkg::XLEN-1:0]     wdata_i,
    output logic [periph_pkg::XLEN-1:0]     rdata_o,

    output logic                            timer_irq_o,
    output logic                            soft_irq_o
);

localparam int AW   = periph_pkg::XLEN;
localparam int PS_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

logic [PS_W-1:0]    ps_cnt_q;
logic               tick;
logic [63:0]        mtime_q;
logic [63:0]        mtimecmp_q;
logic               msip_q;
logic               timer_irq_q;
logic [AW-1:0]      off;
logic               wr;
logic [AW-1:0]      rd_word;

assign off  = addr_i & ~periph_pkg::CLINT_MASK;    // Offset inside the window
assign wr   = sel_i & we_i;
assign tick = (ps_cnt_q == PS_W'(TIMER_PRESCALE - 1));

// Prescaler, one mtime tick per TIMER_PRESCALE clocks
always_ff @(posedge clk) begin
    if (rst_i || tick) begin
        ps_cnt_q <= '0;
    end else begin
        ps_cnt_q <= ps_cnt_q + 1'b1;
    end
end

// A bus write to mtime wins over the tick
always_ff @(posedge clk) begin
    if (rst_i) begin
        mtime_q <= '0;
    end else if (wr && off == periph_pkg::CLINT_MTIME_LO_OFF) begin
        mtime_q[31:0] <= wdata_i;
    end else if (wr && off == periph_pkg::CLINT_MTIME_HI_OFF) begin
        mtime_q[63:32] <= wdata_i;
    end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        mtimecmp_q <= '1;                              // Timer interrupt off
        msip_q     <= 1'b0;
    end else if (wr) begin
        if (off == periph_pkg::CLINT_MTIMECMP_LO_OFF) mtimecmp_q[31:0]  <= wdata_i;
        if (off == periph_pkg::CLINT_MTIMECMP_HI_OFF) mtimecmp_q[63:32] <= wdata_i;
        if (off == periph_pkg::CLINT_MSIP_OFF)        msip_q            <= wdata_i[0];
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        timer_irq_q <= 1'b0;
    end else begin
        timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
end

assign timer_irq_o = timer_irq_q;
assign soft_irq_o  = msip_q;

always_comb begin
    case (off)
        periph_pkg::CLINT_MSIP_OFF:        rd_word = AW'(msip_q);
        periph_pkg::CLINT_MTIMECMP_LO_OFF: rd_word = mtimecmp_q[31:0];
        periph_pkg::CLINT_MTIMECMP_HI_OFF: rd_word = mtimecmp_q[63:32];
        periph_pkg::CLINT_MTIME_LO_OFF:    rd_word = mtime_q[31:0];
        periph_pkg::CLINT_MTIME_HI_OFF:    rd_word = mtime_q[63:32];
        default:                           rd_word = '0;
    endcase
end

// Read word taken at the end of the strobe cycle
always_ff @(posedge clk) begin
    if (sel_i) begin
        rdata_o <= rd_word;
    end
end

endmodule : clint

// File: design/plic.sv
`timescale 1ns/10ps

module plic #(
    parameter int                       PLIC_SOURCES  = 2,
    parameter logic [PLIC_SOURCES-1:0]  PLIC_EDGE_SEL = 2'b01
) (
    input  logic                            clk,
    input  logic                            rst_i,

    input  logic                            sel_i,
    input  logic                            we_i,
    input  logic [periph_pkg::XLEN-1:0]     addr_i,
    input  logic [periph_pkg::XLEN-1:0]     wdata_i,
    output logic [periph_pkg::XLEN-1:0]     rdata_o,

    input  logic [PLIC_SOURCES-1:0]         irq_src_i,
    output logic                            ext_irq_o
);

localparam int AW   = periph_pkg::XLEN;
localparam int PW   = periph_pkg::PLIC_PRIO_W;
localparam int ID_W = $clog2(PLIC_SOURCES + 1);

logic [AW-1:0]              off;
logic [PLIC_SOURCES-1:0]    src_q;
logic [PLIC_SOURCES-1:0]    gate_req;
logic [PLIC_SOURCES:1]      pending_q;      // Indexed by source id
logic [PLIC_SOURCES:1]      enable_q;
logic [PLIC_SOURCES:1]      claimed_q;
logic [PW-1:0]              prio_q [1:PLIC_SOURCES];
logic [PW-1:0]              threshold_q;
logic [PW-1:0]              best_prio;
logic [ID_W-1:0]            best_id;
logic                       claim_rd;
logic                       complete_wr;
logic                       ext_irq_q;
logic [AW-1:0]              rd_word;

assign off         = addr_i & ~periph_pkg::PLIC_MASK;
assign claim_rd    = sel_i & ~we_i & (off == periph_pkg::PLIC_CLAIM_OFF);
assign complete_wr = sel_i &  we_i & (off == periph_pkg::PLIC_CLAIM_OFF);

// Gateways, rising edge or level per source
assign gate_req = (PLIC_EDGE_SEL & irq_src_i & ~src_q) | (~PLIC_EDGE_SEL & irq_src_i);

always_ff @(posedge clk) begin
    if (rst_i) begin
        src_q <= '0;
    end else begin
        src_q <= irq_src_i;
    end
end

// Highest priority above threshold, strict compare keeps the lowest id on ties
always_comb begin
    best_id   = '0;
    best_prio = threshold_q;
    for (int id = 1; id <= PLIC_SOURCES; id++) begin
        if (pending_q[id] && enable_q[id] && prio_q[id] > best_prio) begin
            best_id   = ID_W'(id);
            best_prio = prio_q[id];
        end
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        pending_q <= '0;
        claimed_q <= '0;
    end else begin
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            if (claim_rd && best_id == ID_W'(id)) begin
                pending_q[id] <= 1'b0;
                claimed_q[id] <= 1'b1;
            end else begin
                if (gate_req[id-1] && !claimed_q[id]) pending_q[id] <= 1'b1;
                if (complete_wr && wdata_i == AW'(id)) claimed_q[id] <= 1'b0;
            end
        end
    end
end

// Configuration registers
always_ff @(posedge clk) begin
    if (rst_i) begin
        enable_q    <= '0;
        threshold_q <= '0;
        for (int id = 1; id <= PLIC_SOURCES; id++) prio_q[id] <= '0;
    end else if (sel_i && we_i) begin
        if (off == periph_pkg::PLIC_ENABLE_OFF)    enable_q    <= wdata_i[PLIC_SOURCES:1];
        if (off == periph_pkg::PLIC_THRESHOLD_OFF) threshold_q <= wdata_i[PW-1:0];
        for (int id = 1; id <= PLIC_SOURCES; id++) begin
            if (off == periph_pkg::PLIC_PRIO_OFF + AW'(id * 4)) prio_q[id] <= wdata_i[PW-1:0];
        end
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        ext_irq_q <= 1'b0;
    end else begin
        ext_irq_q <= (best_id != '0);
    end
end

assign ext_irq_o = ext_irq_q;

always_comb begin
    rd_word = '0;
    case (off)
        periph_pkg::PLIC_PENDING_OFF:   rd_word = AW'({pending_q, 1'b0});
        periph_pkg::PLIC_ENABLE_OFF:    rd_word = AW'({enable_q, 1'b0});
        periph_pkg::PLIC_THRESHOLD_OFF: rd_word = AW'(threshold_q);
        periph_pkg::PLIC_CLAIM_OFF:     rd_word = AW'(best_id);     // Claim result
        default: begin
            for (int id = 1; id <= PLIC_SOURCES; id++) begin
                if (off == periph_pkg::PLIC_PRIO_OFF + AW'(id * 4)) rd_word = AW'(prio_q[id]);
            end
        end
    endcase
end

always_ff @(posedge clk) begin
    if (sel_i) begin
        rdata_o <= rd_word;
    end
end

endmodule : plic

// File: design/dbus_interconnect.sv
`timescale 1ns/10ps

module dbus_interconnect (
    input  logic                            clk,
    input  logic                            rst_i,

    // Wishbone classic slave port
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [periph_pkg::XLEN-1:0]     wb_adr_i,
    input  logic [periph_pkg::XLEN-1:0]     wb_dat_i,
    input  logic [periph_pkg::SEL_W-1:0]    wb_sel_i,
    output logic [periph_pkg::XLEN-1:0]     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,

    // Shared request towards the targets
    output logic [periph_pkg::XLEN-1:0]     periph_addr_o,
    output logic [periph_pkg::XLEN-1:0]     periph_wdata_o,
    output logic                            periph_we_o,
    output logic [periph_pkg::SEL_W-1:0]    periph_be_o,

    output logic                            dmem_sel_o,
    output logic                            clint_sel_o,
    output logic                            plic_sel_o,

    input  logic [periph_pkg::XLEN-1:0]     dmem_rdata_i,
    input  logic [periph_pkg::XLEN-1:0]     clint_rdata_i,
    input  logic [periph_pkg::XLEN-1:0]     plic_rdata_i
);

localparam logic [1:0] IDLE   = 2'd0;
localparam logic [1:0] ACCESS = 2'd1;
localparam logic [1:0] DONE   = 2'd2;

// Target codes
localparam logic [1:0] TGT_NONE  = 2'd0;
localparam logic [1:0] TGT_DMEM  = 2'd1;
localparam logic [1:0] TGT_CLINT = 2'd2;
localparam logic [1:0] TGT_PLIC  = 2'd3;

logic [1:0]                         state_q, state_d;
logic [1:0]                         req_tgt, tgt_q;
logic                               req_start;

assign req_start = wb_cyc_i & wb_stb_i & (state_q == IDLE);

// Window decode of the incoming address
always_comb begin
    if ((wb_adr_i & periph_pkg::DMEM_MASK) == periph_pkg::DMEM_BASE) begin
        req_tgt = TGT_DMEM;
    end else if ((wb_adr_i & periph_pkg::CLINT_MASK) == periph_pkg::CLINT_BASE) begin
        req_tgt = TGT_CLINT;
    end else if ((wb_adr_i & periph_pkg::PLIC_MASK) == periph_pkg::PLIC_BASE) begin
        req_tgt = TGT_PLIC;
    end else begin
        req_tgt = TGT_NONE;                          // Unmapped, ends in error
    end
end

always_comb begin
    case (state_q)
        IDLE:    state_d = req_start ? ACCESS : IDLE;
        ACCESS:  state_d = DONE;
        default: state_d = IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        state_q <= IDLE;
    end else begin
        state_q <= state_d;
    end
end

// Request held for the whole access
always_ff @(posedge clk) begin
    if (req_start) begin
        periph_addr_o  <= wb_adr_i;
        periph_wdata_o <= wb_dat_i;
        periph_we_o    <= wb_we_i;
        periph_be_o    <= wb_sel_i;
        tgt_q          <= req_tgt;
    end
end

// One strobe cycle per access
assign dmem_sel_o  = (state_q == ACCESS) && (tgt_q == TGT_DMEM);
assign clint_sel_o = (state_q == ACCESS) && (tgt_q == TGT_CLINT);
assign plic_sel_o  = (state_q == ACCESS) && (tgt_q == TGT_PLIC);

assign wb_ack_o = (state_q == DONE) && (tgt_q != TGT_NONE);
assign wb_err_o = (state_q == DONE) && (tgt_q == TGT_NONE);

// Read mux, targets hold their word from the strobe edge
always_comb begin
    wb_dat_o = '0;
    if (state_q == DONE) begin
        case (tgt_q)
            TGT_DMEM:  wb_dat_o = dmem_rdata_i;
            TGT_CLINT: wb_dat_o = clint_rdata_i;
            TGT_PLIC:  wb_dat_o = plic_rdata_i;
            default:   wb_dat_o = '0;
        endcase
    end
end

endmodule : dbus_interconnect

// File: design/periph_top.sv
`timescale 1ns/10ps

module periph_top #(
    parameter int                       DMEM_WORDS     = 1024,
    parameter int                       TIMER_PRESCALE = 4,
    parameter int                       PLIC_SOURCES   = 2,
    parameter logic [PLIC_SOURCES-1:0]  PLIC_EDGE_SEL  = 2'b01
) (
    input  logic                            clk,
    input  logic                            rst_i,

    // Wishbone classic slave port
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [periph_pkg::XLEN-1:0]     wb_adr_i,
    input  logic [periph_pkg::XLEN-1:0]     wb_dat_i,
    input  logic [periph_pkg::SEL_W-1:0]    wb_sel_i,
    output logic [periph_pkg::XLEN-1:0]     wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o,

    input  logic [PLIC_SOURCES-1:0]         irq_src_i,
    output logic                            timer_irq_o,
    output logic                            soft_irq_o,
    output logic                            ext_irq_o
);

logic [periph_pkg::XLEN-1:0]    periph_addr;
logic [periph_pkg::XLEN-1:0]    periph_wdata;
logic                           periph_we;
logic [periph_pkg::SEL_W-1:0]   periph_be;

// Target strobes from the decoder
logic                           dmem_sel;
logic                           clint_sel;
logic                           plic_sel;

logic [periph_pkg::XLEN-1:0]    dmem_rdata;
logic [periph_pkg::XLEN-1:0]    clint_rdata;
logic [periph_pkg::XLEN-1:0]    plic_rdata;

dbus_interconnect dbus_interconnect_module (
    .clk            (clk),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o),
    .periph_addr_o  (periph_addr),
    .periph_wdata_o (periph_wdata),
    .periph_we_o    (periph_we),
    .periph_be_o    (periph_be),
    .dmem_sel_o     (dmem_sel),
    .clint_sel_o    (clint_sel),
    .plic_sel_o     (plic_sel),
    .dmem_rdata_i   (dmem_rdata),
    .clint_rdata_i  (clint_rdata),
    .plic_rdata_i   (plic_rdata)
);

dmem #(.DMEM_WORDS(DMEM_WORDS)) dmem_module (
    .clk     (clk),
    .rst_i   (rst_i),
    .sel_i   (dmem_sel),
    .we_i    (periph_we),
    .be_i    (periph_be),
    .addr_i  (periph_addr),
    .wdata_i (periph_wdata),
    .rdata_o (dmem_rdata)
);

// Full-word registers only, no byte lanes here
clint #(.TIMER_PRESCALE(TIMER_PRESCALE)) clint_module (
    .clk         (clk),
    .rst_i       (rst_i),
    .sel_i       (clint_sel),
    .we_i        (periph_we),
    .addr_i      (periph_addr),
    .wdata_i     (periph_wdata),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o),
    .soft_irq_o  (soft_irq_o)
);

plic #(
    .PLIC_SOURCES  (PLIC_SOURCES),
    .PLIC_EDGE_SEL (PLIC_EDGE_SEL)
) plic_module (
    .clk       (clk),
    .rst_i     (rst_i),
    .sel_i     (plic_sel),
    .we_i      (periph_we),
    .addr_i    (periph_addr),
    .wdata_i   (periph_wdata),
    .rdata_o   (plic_rdata),
    .irq_src_i (irq_src_i),
    .ext_irq_o (ext_irq_o)
);

endmodule : periph_top

// File: tests/periph_props.sv
`timescale 1ns/10ps

module periph_props (
    input logic clk,
    input logic rst_i,
    input logic req_start_i,    // Request taken in IDLE
    input logic ack_i,
    input logic err_i
);

a_resp_excl: assert property (@(posedge clk) disable iff (rst_i) !(ack_i && err_i))
    else $error("wb_ack_o and wb_err_o high in the same cycle");

a_ack_one: assert property (@(posedge clk) disable iff (rst_i) ack_i |=> !ack_i)
    else $error("wb_ack_o high for more than one cycle");

a_err_one: assert property (@(posedge clk) disable iff (rst_i) err_i |=> !err_i)
    else $error("wb_err_o high for more than one cycle");

// Response exactly two cycles after the request edge
a_req_resp: assert property (@(posedge clk) disable iff (rst_i)
                             req_start_i |-> ##2 (ack_i || err_i))
    else $error("no response two cycles after a request");

a_resp_req: assert property (@(posedge clk) disable iff (rst_i)
                             (ack_i || err_i) |-> $past(req_start_i, 2))
    else $error("response without a request two cycles earlier");

endmodule : periph_props

bind dbus_interconnect periph_props props_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_start_i (req_start),
    .ack_i       (wb_ack_o),
    .err_i       (wb_err_o)
);

// File: tests/periph_tb.sv
`timescale 1ns/10ps

module periph_tb;

localparam int DW             = periph_pkg::XLEN;
localparam int SW             = periph_pkg::SEL_W;
localparam int TIMER_PRESCALE = 4;      // Default of periph_top
localparam int ROWS           = 15;
localparam int WB_TMO         = 20;     // Cycles allowed for one bus response
localparam int IRQ_TMO        = 200;
localparam int IRQ_TIMER      = 0;
localparam int IRQ_SOFT       = 1;
localparam int IRQ_EXT        = 2;

localparam logic [DW-1:0] DMEM       = periph_pkg::DMEM_BASE;
localparam logic [DW-1:0] MSIP       = periph_pkg::CLINT_BASE + periph_pkg::CLINT_MSIP_OFF;
localparam logic [DW-1:0] MTIMECMP_LO = periph_pkg::CLINT_BASE + periph_pkg::CLINT_MTIMECMP_LO_OFF;
localparam logic [DW-1:0] MTIMECMP_HI = periph_pkg::CLINT_BASE + periph_pkg::CLINT_MTIMECMP_HI_OFF;
localparam logic [DW-1:0] MTIME_LO   = periph_pkg::CLINT_BASE + periph_pkg::CLINT_MTIME_LO_OFF;
localparam logic [DW-1:0] PRIO       = periph_pkg::PLIC_BASE + periph_pkg::PLIC_PRIO_OFF;
localparam logic [DW-1:0] PENDING    = periph_pkg::PLIC_BASE + periph_pkg::PLIC_PENDING_OFF;
localparam logic [DW-1:0] ENABLE     = periph_pkg::PLIC_BASE + periph_pkg::PLIC_ENABLE_OFF;
localparam logic [DW-1:0] THRESHOLD  = periph_pkg::PLIC_BASE + periph_pkg::PLIC_THRESHOLD_OFF;
localparam logic [DW-1:0] CLAIM      = periph_pkg::PLIC_BASE + periph_pkg::PLIC_CLAIM_OFF;

logic           clk = 1'b0;
logic           rst_i;
logic           wb_cyc_i;
logic           wb_stb_i;
logic           wb_we_i;
logic [DW-1:0]  wb_adr_i;
logic [DW-1:0]  wb_dat_i;
logic [SW-1:0]  wb_sel_i;
logic [DW-1:0]  wb_dat_o;
logic           wb_ack_o;
logic           wb_err_o;
logic [1:0]     irq_src_i;      // Source 1 edge, source 2 level
logic           timer_irq_o;
logic           soft_irq_o;
logic           ext_irq_o;

int             errors   = 0;
int             timeouts = 0;
int unsigned    cycle_cnt = 0;
logic [31:0]    rng = 32'h850a_56c0;

// Stimulus table
logic           t_we  [ROWS];
logic [DW-1:0]  t_adr [ROWS];
logic [DW-1:0]  t_dat [ROWS];
logic [SW-1:0]  t_sel [ROWS];
logic [DW-1:0]  t_exp [ROWS];
logic           t_err [ROWS];

always #10 clk = ~clk;

always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

periph_top dut_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .irq_src_i   (irq_src_i),
    .timer_irq_o (timer_irq_o),
    .soft_irq_o  (soft_irq_o),
    .ext_irq_o   (ext_irq_o)
);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Enabled lanes take the new bytes
function automatic logic [DW-1:0] merge_lanes(input logic [DW-1:0] old_w,
                                              input logic [DW-1:0] new_w,
                                              input logic [SW-1:0] sel);
    logic [DW-1:0] m;
    for (int b = 0; b < SW; b++) begin
        m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return m;
endfunction

task automatic check_val(input string name, input logic [DW-1:0] got,
                         input logic [DW-1:0] exp);
    assert (got === exp) else begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
endtask

task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
endtask

// One Wishbone classic cycle, response sampled at the falling edge
task automatic wb_access(input logic we, input logic [DW-1:0] adr, input logic [DW-1:0] dat,
                         input logic [SW-1:0] sel, output logic [DW-1:0] rdata,
                         output logic err);
    int   lat;
    logic done;
    @(posedge clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    @(posedge clk);                     // Edge that samples the request
    lat  = 0;
    done = 1'b0;
    while (!done && lat < WB_TMO) begin
        @(negedge clk);
        lat++;
        done = wb_ack_o | wb_err_o;
    end
    rdata = wb_dat_o;
    err   = wb_err_o;
    if (!done) begin
        report_timeout("a bus acknowledge or error");
    end else begin
        check_val("response latency", lat, 2);
        check_val("wb_ack_o & wb_err_o", wb_ack_o & wb_err_o, 0);
    end
    @(posedge clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    @(negedge clk);
    check_val("wb_ack_o | wb_err_o after response", wb_ack_o | wb_err_o, 0);
endtask

task automatic bus_write(input logic [DW-1:0] adr, input logic [DW-1:0] dat);
    logic [DW-1:0] rd;
    logic          err;
    wb_access(1'b1, adr, dat, '1, rd, err);
    check_val("wb_err_o", err, 0);
endtask

task automatic bus_read(input logic [DW-1:0] adr, output logic [DW-1:0] rd);
    logic err;
    wb_access(1'b0, adr, '0, '1, rd, err);
    check_val("wb_err_o", err, 0);
endtask

task automatic wait_irq(input int which, input logic level, input string name);
    logic cur;
    int   n;
    n   = 0;
    cur = ~level;
    while (cur !== level && n < IRQ_TMO) begin
        @(negedge clk);
        n++;
        case (which)
            IRQ_TIMER: cur = timer_irq_o;
            IRQ_SOFT:  cur = soft_irq_o;
            default:   cur = ext_irq_o;
        endcase
    end
    if (cur !== level) begin
        report_timeout(name);
    end
endtask

task automatic set_row(input int i, input logic we, input logic [DW-1:0] adr,
                       input logic [DW-1:0] dat, input logic [SW-1:0] sel,
                       input logic [DW-1:0] exp, input logic err);
    t_we[i]  = we;
    t_adr[i] = adr;
    t_dat[i] = dat;
    t_sel[i] = sel;
    t_exp[i] = exp;
    t_err[i] = err;
endtask

task automatic fill_table();
    logic [DW-1:0] adrs  [4];
    logic [DW-1:0] words [4];
    logic [DW-1:0] m0;
    logic [DW-1:0] m1;
    adrs = '{DMEM + 32'h000, DMEM + 32'h010, DMEM + 32'h7FC, DMEM + 32'hFFC};
    for (int k = 0; k < 4; k++) begin
        rng      = xorshift32(rng);
        words[k] = rng;
        set_row(k, 1'b1, adrs[k], words[k], 4'hF, '0, 1'b0);
        set_row(k + 4, 1'b0, adrs[k], '0, 4'hF, words[k], 1'b0);
    end
    rng = xorshift32(rng);
    m0  = merge_lanes(words[0], rng, 4'b0011);
    set_row(8, 1'b1, adrs[0], rng, 4'b0011, '0, 1'b0);
    set_row(9, 1'b0, adrs[0], '0, 4'hF, m0, 1'b0);
    rng = xorshift32(rng);
    m1  = merge_lanes(words[1], rng, 4'b1000);
    set_row(10, 1'b1, adrs[1], rng, 4'b1000, '0, 1'b0);
    set_row(11, 1'b0, adrs[1], '0, 4'hF, m1, 1'b0);
    // Unmapped, low bits alias the word at offset 0x10
    set_row(12, 1'b1, 32'h9000_0010, ~m1, 4'hF, '0, 1'b1);
    set_row(13, 1'b0, 32'h1000_0000, '0, 4'hF, '0, 1'b1);
    set_row(14, 1'b0, adrs[1], '0, 4'hF, m1, 1'b0);
endtask

initial begin
    logic [DW-1:0] rd;
    logic [DW-1:0] t0;
    logic [DW-1:0] t1;
    logic          err;
    int unsigned   c0;
    int unsigned   c1;
    int            delta;
    int            nominal;

    rst_i     = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    irq_src_i = '0;
    fill_table();
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_val("wb_ack_o", wb_ack_o, 0);
    check_val("wb_err_o", wb_err_o, 0);
    check_val("timer_irq_o", timer_irq_o, 0);
    check_val("soft_irq_o", soft_irq_o, 0);
    check_val("ext_irq_o", ext_irq_o, 0);

    // Data memory rows
    for (int i = 0; i < ROWS; i++) begin
        wb_access(t_we[i], t_adr[i], t_dat[i], t_sel[i], rd, err);
        check_val("wb_err_o", err, t_err[i]);
        if (!t_we[i] && !t_err[i]) begin
            check_val("wb_dat_o", rd, t_exp[i]);
        end
    end

    // Timer rate
    bus_read(MTIME_LO, t0);
    c0 = cycle_cnt;
    repeat (40) @(posedge clk);
    bus_read(MTIME_LO, t1);
    c1      = cycle_cnt;
    delta   = int'(t1 - t0);
    nominal = int'((c1 - c0) / TIMER_PRESCALE);
    assert (delta >= nominal - 1 && delta <= nominal + 1) else begin
        errors++;
        $display("CHECK FAILED at %0t: mtime delta expected %0d +/- 1, got %0d",
                 $time, nominal, delta);
    end

    // Timer compare
    check_val("timer_irq_o", timer_irq_o, 0);
    bus_write(MTIMECMP_HI, '0);
    bus_read(MTIME_LO, t0);
    bus_write(MTIMECMP_LO, t0 + 5);
    wait_irq(IRQ_TIMER, 1'b1, "timer_irq_o to rise");
    bus_write(MTIMECMP_LO, '1);
    bus_write(MTIMECMP_HI, '1);
    wait_irq(IRQ_TIMER, 1'b0, "timer_irq_o to fall");

    // Software interrupt
    bus_write(MSIP, 32'd1);
    wait_irq(IRQ_SOFT, 1'b1, "soft_irq_o to rise");
    bus_read(MSIP, rd);
    check_val("msip", rd, 32'd1);
    bus_write(MSIP, 32'd0);
    wait_irq(IRQ_SOFT, 1'b0, "soft_irq_o to fall");
    bus_read(MSIP, rd);
    check_val("msip", rd, 32'd0);

    // PLIC arbitration
    bus_write(PRIO + 32'd4, 32'd2);
    bus_write(PRIO + 32'd8, 32'd5);
    bus_write(ENABLE, 32'h6);
    check_val("ext_irq_o", ext_irq_o, 0);
    @(posedge clk);
    irq_src_i <= 2'b11;
    wait_irq(IRQ_EXT, 1'b1, "ext_irq_o to rise");
    @(posedge clk);
    irq_src_i <= 2'b10;                 // Level source stays high
    bus_read(CLAIM, rd);
    check_val("claim id", rd, 32'd2);
    bus_read(CLAIM, rd);
    check_val("claim id", rd, 32'd1);
    bus_read(CLAIM, rd);
    check_val("claim id", rd, 32'd0);
    bus_read(PENDING, rd);
    check_val("pending while claimed", rd, 32'h0);
    check_val("ext_irq_o", ext_irq_o, 0);
    bus_write(CLAIM, 32'd2);            // Complete source 2
    bus_read(PENDING, rd);
    check_val("pending after complete", rd, 32'h4);
    bus_write(CLAIM, 32'd1);
    wait_irq(IRQ_EXT, 1'b1, "ext_irq_o to rise again");
    bus_write(THRESHOLD, 32'd5);
    wait_irq(IRQ_EXT, 1'b0, "ext_irq_o to fall at threshold 5");
    repeat (5) @(negedge clk);
    check_val("ext_irq_o", ext_irq_o, 0);
    bus_read(CLAIM, rd);
    check_val("claim id at threshold", rd, 32'd0);

    $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule : periph_tb

// File: list.f
design/periph_pkg.sv
design/dmem.sv
design/clint.sv
design/plic.sv
design/dbus_interconnect.sv
design/periph_top.sv
tests/periph_props.sv
tests/periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_tb --Mdir "$OBJ_DIR" -o periph_sim -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$OBJ_DIR/periph_sim" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The testbench prints its fail message on any failed check or timeout
if grep -q "Test FAILED" "$SIM_LOG"; then
    echo "Failure reported in $SIM_LOG"
    exit 1
fi

echo "No failure found in $SIM_LOG"
exit 0
